// ==== flist.f ====
+incdir+hdl
hdl/vec_pkg.sv
hdl/vec_dispatcher.sv
hdl/vec_sequencer.sv
hdl/vec_lane.sv
hdl/vec_top.sv
sim/tb_vec_top.sv

// ==== hdl/vec_dispatcher.sv ====
// Vector dispatcher
// Instruction queue facing the scalar core
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Core side, credit based
  input  logic      insn_valid_i,
  input  vec_op_e   insn_op_i,
  input  vreg_idx_t insn_vd_i,
  input  vreg_idx_t insn_vs1_i,
  input  vreg_idx_t insn_vs2_i,
  input  elem_t     insn_scalar_i,
  output logic      insn_credit_o,
  // Sequencer side, valid/ready
  output logic      seq_valid_o,
  input  logic      seq_ready_i,
  output vec_op_e   seq_op_o,
  output vreg_idx_t seq_vd_o,
  output vreg_idx_t seq_vs1_o,
  output vreg_idx_t seq_vs2_o,
  output elem_t     seq_scalar_o,
  input  logic      seq_busy_i,
  output logic      idle_o
);

  localparam int unsigned depth = `VEC_INSN_QUEUE_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  vec_op_e          op_q     [depth];
  vreg_idx_t        vd_q     [depth];
  vreg_idx_t        vs1_q    [depth];
  vreg_idx_t        vs2_q    [depth];
  elem_t            scalar_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count_q == cnt_w'(depth));
  assign push = insn_valid_i && !full;
  assign pop  = seq_valid_o && seq_ready_i;

  ////////////////////
  // Queue storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]     <= insn_op_i;
      vd_q[wr_ptr_q]     <= insn_vd_i;
      vs1_q[wr_ptr_q]    <= insn_vs1_i;
      vs2_q[wr_ptr_q]    <= insn_vs2_i;
      scalar_q[wr_ptr_q] <= insn_scalar_i;
    end
  end

  // Pointers, occupancy and credit return
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      insn_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_w'(push) - cnt_w'(pop);
      // Slot is already free when the core sees the credit
      insn_credit_o <= pop;
    end
  end

  // Head entry toward the sequencer
  assign seq_valid_o  = (count_q != '0);
  assign seq_op_o     = op_q[rd_ptr_q];
  assign seq_vd_o     = vd_q[rd_ptr_q];
  assign seq_vs1_o    = vs1_q[rd_ptr_q];
  assign seq_vs2_o    = vs2_q[rd_ptr_q];
  assign seq_scalar_o = scalar_q[rd_ptr_q];

  assign idle_o = (count_q == '0) && !seq_busy_i;

  // Core must hold a credit for every instruction it sends
  a_no_insn_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) insn_valid_i |-> !full
  ) else $error("vec_dispatcher: instruction received while queue is full");

endmodule

// ==== hdl/vec_lane.sv ====
// Vector lane
// Register file slice and element ALU
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_lane import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Broadcast from the sequencer
  input  logic      lane_valid_i,
  output logic      lane_ready_o,
  input  vec_op_e   lane_op_i,
  input  vreg_idx_t lane_vd_i,
  input  vreg_idx_t lane_vs1_i,
  input  vreg_idx_t lane_vs2_i,
  input  elem_t     lane_scalar_i,
  // Completion
  output logic      lane_done_o,
  output elem_t     lane_sum_o,
  output elem_t     lane_first_o
);

  localparam int unsigned nr_vregs = `VEC_NR_VREGS;
  localparam int unsigned nr_slots = `VEC_ELEMS_PER_LANE;
  localparam int unsigned q_depth  = `VEC_LANE_QUEUE_DEPTH;
  localparam int unsigned qptr_w   = (q_depth > 1) ? $clog2(q_depth) : 1;
  localparam int unsigned qcnt_w   = $clog2(q_depth + 1);

  elem_t             vrf_q [nr_vregs][nr_slots];
  vec_op_e           op_q     [q_depth];
  vreg_idx_t         vd_q     [q_depth];
  vreg_idx_t         vs1_q    [q_depth];
  vreg_idx_t         vs2_q    [q_depth];
  elem_t             scalar_q [q_depth];
  logic [qptr_w-1:0] wr_ptr_q;
  logic [qptr_w-1:0] rd_ptr_q;
  logic [qcnt_w-1:0] count_q;
  lane_state_e       state_q;
  lane_state_e       state_d;
  slot_idx_t         slot_q;
  elem_t             sum_q;
  elem_t             first_q;
  logic              push;
  logic              pop;
  logic              last_slot;
  logic              wr_en;
  elem_t             opnd_a;
  elem_t             opnd_b;
  elem_t             result;

  assign lane_ready_o = (count_q != qcnt_w'(q_depth));
  assign push         = lane_valid_i && lane_ready_o;
  assign last_slot    = (slot_q == slot_idx_t'(nr_slots - 1));
  assign pop          = (state_q == LANE_EXEC) && last_slot;
  assign lane_done_o  = pop;

  ////////////////////
  // Instruction queue
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]     <= lane_op_i;
      vd_q[wr_ptr_q]     <= lane_vd_i;
      vs1_q[wr_ptr_q]    <= lane_vs1_i;
      vs2_q[wr_ptr_q]    <= lane_vs2_i;
      scalar_q[wr_ptr_q] <= lane_scalar_i;
    end
  end

  // Next state, execution runs as long as the queue holds work
  always_comb begin
    state_d = state_q;
    case (state_q)
      LANE_IDLE: if (push) state_d = LANE_EXEC;
      LANE_EXEC: if (pop && count_q == qcnt_w'(1) && !push) state_d = LANE_IDLE;
      default:   state_d = LANE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= LANE_IDLE;
      slot_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == qptr_w'(q_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == qptr_w'(q_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + qcnt_w'(push) - qcnt_w'(pop);
      state_q <= state_d;
      if (state_q == LANE_EXEC) begin
        slot_q <= last_slot ? '0 : slot_q + 1'b1;
      end
    end
  end

  ////////////////////
  // Element ALU
  ////////////////////

  // Head entry is the instruction being executed
  assign opnd_a = vrf_q[vs1_q[rd_ptr_q]][slot_q];
  assign opnd_b = vrf_q[vs2_q[rd_ptr_q]][slot_q];

  always_comb begin
    wr_en  = 1'b1;
    result = '0;
    case (op_q[rd_ptr_q])
      VADD:    result = opnd_b + opnd_a;
      // vs2 minus vs1
      VSUB:    result = opnd_b - opnd_a;
      VAND:    result = opnd_b & opnd_a;
      VOR:     result = opnd_b | opnd_a;
      VXOR:    result = opnd_b ^ opnd_a;
      VMV_VX:  result = scalar_q[rd_ptr_q];
      default: wr_en  = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < nr_vregs; r++) begin
        for (int s = 0; s < nr_slots; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (state_q == LANE_EXEC && wr_en) begin
      vrf_q[vd_q[rd_ptr_q]][slot_q] <= result;
    end
  end

  // Running vs2 sum and slot 0 capture, restarted at each instruction
  always_ff @(posedge clk_i) begin
    if (state_q == LANE_EXEC) begin
      sum_q <= lane_sum_o;
      if (slot_q == '0) begin
        first_q <= opnd_b;
      end
    end
  end

  assign lane_sum_o   = (slot_q == '0) ? opnd_b : sum_q + opnd_b;
  assign lane_first_o = (slot_q == '0) ? opnd_b : first_q;

  // Sequencer only broadcasts when every lane has room
  a_valid_needs_ready: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) lane_valid_i |-> lane_ready_o
  ) else $error("vec_lane: broadcast while lane queue is full");

endmodule

// ==== hdl/vec_pkg.sv ====
// Vector coprocessor types
`include "vec_settings.svh"

package vec_pkg;

  // One vector element
  typedef logic [`VEC_ELEM_WIDTH-1:0] elem_t;

  // Vector register number
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  // Element slot inside one lane
  typedef logic [$clog2(`VEC_ELEMS_PER_LANE)-1:0] slot_idx_t;

  // Vector opcodes
  typedef enum logic [2:0] {
    VADD    = 3'd0,
    VSUB    = 3'd1,
    VAND    = 3'd2,
    VOR     = 3'd3,
    VXOR    = 3'd4,
    VMV_VX  = 3'd5,  // scalar broadcast into vd
    VMV_XS  = 3'd6,  // element 0 of vs2 back to the core
    VREDSUM = 3'd7   // sum of all elements of vs2
  } vec_op_e;

  // Lane execution state
  typedef enum logic {
    LANE_IDLE = 1'b0,
    LANE_EXEC = 1'b1
  } lane_state_e;

endpackage

// ==== hdl/vec_sequencer.sv ====
// Vector sequencer
// Lane broadcast and scalar responses
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Dispatcher side
  input  logic                     seq_valid_i,
  output logic                     seq_ready_o,
  input  vec_op_e                  seq_op_i,
  input  vreg_idx_t                seq_vd_i,
  input  vreg_idx_t                seq_vs1_i,
  input  vreg_idx_t                seq_vs2_i,
  input  elem_t                    seq_scalar_i,
  output logic                     seq_busy_o,
  // Lane broadcast
  output logic                     lane_valid_o,
  input  logic [`VEC_NR_LANES-1:0] lane_ready_i,
  output vec_op_e                  lane_op_o,
  output vreg_idx_t                lane_vd_o,
  output vreg_idx_t                lane_vs1_o,
  output vreg_idx_t                lane_vs2_o,
  output elem_t                    lane_scalar_o,
  // Lane completion
  input  logic [`VEC_NR_LANES-1:0] lane_done_i,
  input  elem_t                    lane_sum_i   [`VEC_NR_LANES],
  input  elem_t                    lane_first_i [`VEC_NR_LANES],
  // Scalar response to the core
  output logic                     resp_valid_o,
  output elem_t                    resp_data_o
);

  localparam int unsigned nr_lanes     = `VEC_NR_LANES;
  localparam int unsigned flight_depth = `VEC_LANE_QUEUE_DEPTH + 1;
  localparam int unsigned fptr_w       = (flight_depth > 1) ? $clog2(flight_depth) : 1;
  localparam int unsigned fcnt_w       = $clog2(flight_depth + 1);

  logic              hold_valid_q;
  logic              accept;
  logic              issue;
  logic              retire;
  logic              flight_full;
  vec_op_e           flight_op_q [flight_depth];
  logic [fptr_w-1:0] fwr_ptr_q;
  logic [fptr_w-1:0] frd_ptr_q;
  logic [fcnt_w-1:0] fcount_q;
  vec_op_e           retire_op;
  elem_t             red_sum;

  assign flight_full  = (fcount_q == fcnt_w'(flight_depth));
  assign issue        = hold_valid_q && (&lane_ready_i) && !flight_full;
  assign seq_ready_o  = !hold_valid_q || issue;
  assign accept       = seq_valid_i && seq_ready_o;
  assign lane_valid_o = issue;
  // Lanes run in lockstep, lane 0 stands for all of them
  assign retire       = lane_done_i[0];
  assign retire_op    = flight_op_q[frd_ptr_q];
  assign seq_busy_o   = hold_valid_q || (fcount_q != '0);

  ////////////////////
  // Broadcast stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      lane_op_o     <= seq_op_i;
      lane_vd_o     <= seq_vd_i;
      lane_vs1_o    <= seq_vs1_i;
      lane_vs2_o    <= seq_vs2_i;
      lane_scalar_o <= seq_scalar_i;
    end
  end

  ////////////////////
  // In-flight ops
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (issue) begin
      flight_op_q[fwr_ptr_q] <= lane_op_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= 1'b0;
      fwr_ptr_q    <= '0;
      frd_ptr_q    <= '0;
      fcount_q     <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      if (accept) begin
        hold_valid_q <= 1'b1;
      end else if (issue) begin
        hold_valid_q <= 1'b0;
      end
      if (issue) begin
        fwr_ptr_q <= (fwr_ptr_q == fptr_w'(flight_depth - 1)) ? '0 : fwr_ptr_q + 1'b1;
      end
      if (retire) begin
        frd_ptr_q <= (frd_ptr_q == fptr_w'(flight_depth - 1)) ? '0 : frd_ptr_q + 1'b1;
      end
      fcount_q     <= fcount_q + fcnt_w'(issue) - fcnt_w'(retire);
      resp_valid_o <= retire && (retire_op == VMV_XS || retire_op == VREDSUM);
    end
  end

  // Wrapping sum of the lane partial sums
  always_comb begin
    red_sum = '0;
    for (int i = 0; i < nr_lanes; i++) begin
      red_sum = red_sum + lane_sum_i[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      resp_data_o <= (retire_op == VMV_XS) ? lane_first_i[0] : red_sum;
    end
  end

  // All lanes finish each instruction on the same edge
  a_lanes_lockstep: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (lane_done_i == '0) || (lane_done_i == '1)
  ) else $error("vec_sequencer: lanes out of lockstep, done = %b", lane_done_i);

endmodule

// ==== hdl/vec_settings.svh ====
// Vector coprocessor sizes
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Lane array geometry
`define VEC_NR_LANES         4
`define VEC_ELEMS_PER_LANE   4
`define VEC_ELEM_WIDTH       32

// Architectural registers
`define VEC_NR_VREGS         32

// Queue depths
// The dispatcher depth is also the core's credit count after reset
`define VEC_INSN_QUEUE_DEPTH 4
`define VEC_LANE_QUEUE_DEPTH 2

`endif

// ==== hdl/vec_top.sv ====
// Vector coprocessor top level
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Instruction port from the core
  input  logic      insn_valid_i,
  input  vec_op_e   insn_op_i,
  input  vreg_idx_t insn_vd_i,
  input  vreg_idx_t insn_vs1_i,
  input  vreg_idx_t insn_vs2_i,
  input  elem_t     insn_scalar_i,
  output logic      insn_credit_o,
  // Scalar responses, no back-pressure
  output logic      resp_valid_o,
  output elem_t     resp_data_o,
  output logic      idle_o
);

  ////////////////////
  // Dispatcher
  ////////////////////

  logic      seq_valid;
  logic      seq_ready;
  vec_op_e   seq_op;
  vreg_idx_t seq_vd;
  vreg_idx_t seq_vs1;
  vreg_idx_t seq_vs2;
  elem_t     seq_scalar;
  logic      seq_busy;

  vec_dispatcher u_dispatcher (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .insn_valid_i (insn_valid_i ),
    .insn_op_i    (insn_op_i    ),
    .insn_vd_i    (insn_vd_i    ),
    .insn_vs1_i   (insn_vs1_i   ),
    .insn_vs2_i   (insn_vs2_i   ),
    .insn_scalar_i(insn_scalar_i),
    .insn_credit_o(insn_credit_o),
    .seq_valid_o  (seq_valid    ),
    .seq_ready_i  (seq_ready    ),
    .seq_op_o     (seq_op       ),
    .seq_vd_o     (seq_vd       ),
    .seq_vs1_o    (seq_vs1      ),
    .seq_vs2_o    (seq_vs2      ),
    .seq_scalar_o (seq_scalar   ),
    .seq_busy_i   (seq_busy     ),
    .idle_o       (idle_o       )
  );

  ////////////////////
  // Sequencer
  ////////////////////

  logic                     lane_valid;
  logic [`VEC_NR_LANES-1:0] lane_ready;
  vec_op_e                  lane_op;
  vreg_idx_t                lane_vd;
  vreg_idx_t                lane_vs1;
  vreg_idx_t                lane_vs2;
  elem_t                    lane_scalar;
  logic [`VEC_NR_LANES-1:0] lane_done;
  elem_t                    lane_sum   [`VEC_NR_LANES];
  elem_t                    lane_first [`VEC_NR_LANES];

  vec_sequencer u_sequencer (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .seq_valid_i  (seq_valid   ),
    .seq_ready_o  (seq_ready   ),
    .seq_op_i     (seq_op      ),
    .seq_vd_i     (seq_vd      ),
    .seq_vs1_i    (seq_vs1     ),
    .seq_vs2_i    (seq_vs2     ),
    .seq_scalar_i (seq_scalar  ),
    .seq_busy_o   (seq_busy    ),
    .lane_valid_o (lane_valid  ),
    .lane_ready_i (lane_ready  ),
    .lane_op_o    (lane_op     ),
    .lane_vd_o    (lane_vd     ),
    .lane_vs1_o   (lane_vs1    ),
    .lane_vs2_o   (lane_vs2    ),
    .lane_scalar_o(lane_scalar ),
    .lane_done_i  (lane_done   ),
    .lane_sum_i   (lane_sum    ),
    .lane_first_i (lane_first  ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o )
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane u_lane (
      .clk_i        (clk_i        ),
      .rst_n_i      (rst_n_i      ),
      .lane_valid_i (lane_valid   ),
      .lane_ready_o (lane_ready[l]),
      .lane_op_i    (lane_op      ),
      .lane_vd_i    (lane_vd      ),
      .lane_vs1_i   (lane_vs1     ),
      .lane_vs2_i   (lane_vs2     ),
      .lane_scalar_i(lane_scalar  ),
      .lane_done_o  (lane_done[l] ),
      .lane_sum_o   (lane_sum[l]  ),
      .lane_first_o (lane_first[l])
    );
  end : gen_lanes

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the vector coprocessor simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_vec_top \
  -o sim_vec_top

# The simulator status is not trusted alone, the log decides
./obj_dir/sim_vec_top > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

// ==== sim/tb_vec_top.sv ====
// Vector coprocessor testbench
`timescale 1ns/1ps
`include "vec_settings.svh"

module tb_vec_top import vec_pkg::*; ();

  localparam int nr_lanes       = `VEC_NR_LANES;
  localparam int nr_elems       = `VEC_NR_LANES * `VEC_ELEMS_PER_LANE;
  localparam int nr_vregs       = `VEC_NR_VREGS;
  localparam int queue_depth    = `VEC_INSN_QUEUE_DEPTH;
  localparam int timeout_cycles = 2000;

  logic      clk_i;
  logic      rst_n_i;
  logic      insn_valid_i;
  vec_op_e   insn_op_i;
  vreg_idx_t insn_vd_i;
  vreg_idx_t insn_vs1_i;
  vreg_idx_t insn_vs2_i;
  elem_t     insn_scalar_i;
  logic      insn_credit_o;
  logic      resp_valid_o;
  elem_t     resp_data_o;
  logic      idle_o;

  int        seed;
  int        errors;
  int        tests_run;
  int        credits;
  int        resp_count;
  int        resp_expected;
  int        errs_before;
  int        r;
  elem_t     scalar;
  vreg_idx_t vreg;
  elem_t     exp_q [$];
  elem_t     resp_log [$];
  // Flat element index per register
  // elem_of gives the lane mapping
  elem_t     vreg_model [nr_vregs][nr_elems];

  vec_top u_dut (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .insn_valid_i (insn_valid_i ),
    .insn_op_i    (insn_op_i    ),
    .insn_vd_i    (insn_vd_i    ),
    .insn_vs1_i   (insn_vs1_i   ),
    .insn_vs2_i   (insn_vs2_i   ),
    .insn_scalar_i(insn_scalar_i),
    .insn_credit_o(insn_credit_o),
    .resp_valid_o (resp_valid_o ),
    .resp_data_o  (resp_data_o  ),
    .idle_o       (idle_o       )
  );

  always #5 clk_i = ~clk_i;

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_elem(input string name, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Element i sits in lane i mod nr_lanes at slot i / nr_lanes
  function automatic int elem_of(input int lane, input int slot);
    return slot * nr_lanes + lane;
  endfunction

  task automatic apply_model(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                             input vreg_idx_t vs2, input elem_t scalar_v);
    elem_t a;
    elem_t b;
    elem_t sum;
    sum = '0;
    for (int i = 0; i < nr_elems; i++) begin
      a = vreg_model[vs1][i];
      b = vreg_model[vs2][i];
      case (op)
        VADD:    vreg_model[vd][i] = b + a;
        VSUB:    vreg_model[vd][i] = b - a;
        VAND:    vreg_model[vd][i] = b & a;
        VOR:     vreg_model[vd][i] = b | a;
        VXOR:    vreg_model[vd][i] = b ^ a;
        VMV_VX:  vreg_model[vd][i] = scalar_v;
        default: sum = sum + b;
      endcase
    end
    if (op == VMV_XS) begin
      exp_q.push_back(vreg_model[vs2][elem_of(0, 0)]);
      resp_expected++;
    end else if (op == VREDSUM) begin
      exp_q.push_back(sum);
      resp_expected++;
    end
  endtask

  ////////////////////
  // Driver and waits
  ////////////////////

  // Sends one instruction on a falling edge once a credit is held
  task automatic send_insn(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input elem_t scalar_v);
    int  waited;
    logic sent;
    waited = 0;
    sent   = 1'b0;
    while (!sent && waited < timeout_cycles) begin
      @(negedge clk_i);
      insn_valid_i = 1'b0;
      if (credits > 0) begin
        insn_valid_i  = 1'b1;
        insn_op_i     = op;
        insn_vd_i     = vd;
        insn_vs1_i    = vs1;
        insn_vs2_i    = vs2;
        insn_scalar_i = scalar_v;
        credits--;
        apply_model(op, vd, vs1, vs2, scalar_v);
        sent = 1'b1;
      end else begin
        waited++;
      end
    end
    if (!sent) begin
      $display("No credit came back within %0d cycles", timeout_cycles);
      errors++;
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    // Last instruction was just queued
    check_count("idle_o", int'(idle_o), 0);
    while (!idle_o && waited < timeout_cycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (!idle_o) begin
      $display("DUT did not go idle within %0d cycles", timeout_cycles);
      errors++;
    end
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (resp_count < resp_expected && waited < timeout_cycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (resp_count < resp_expected) begin
      $display("%0d responses still missing after %0d cycles", resp_expected - resp_count,
               timeout_cycles);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errors - errs_at_start);
    end
  endtask

  // Credit return and response monitor
  // Values read here are the ones from before the edge
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (insn_credit_o) begin
        credits++;
        if (credits > queue_depth) begin
          $display("Credit counter rose above the queue depth to %0d", credits);
          errors++;
        end
      end
      if (resp_valid_o) begin
        resp_count++;
        resp_log.push_back(resp_data_o);
        if (exp_q.size() == 0) begin
          $display("Response arrived while none was expected");
          errors++;
        end else begin
          check_elem("resp_data_o", resp_data_o, exp_q.pop_front());
        end
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    insn_valid_i  = 1'b0;
    insn_op_i     = VADD;
    insn_vd_i     = '0;
    insn_vs1_i    = '0;
    insn_vs2_i    = '0;
    insn_scalar_i = '0;
    seed          = 43849;
    errors        = 0;
    tests_run     = 0;
    credits       = queue_depth;
    resp_count    = 0;
    resp_expected = 0;
    for (int v = 0; v < nr_vregs; v++) begin
      for (int i = 0; i < nr_elems; i++) begin
        vreg_model[v][i] = '0;
      end
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset state
    errs_before = errors;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk_i);
      check_count("idle_o", int'(idle_o), 1);
      check_count("resp_valid_o", int'(resp_valid_o), 0);
      check_count("insn_credit_o", int'(insn_credit_o), 0);
    end
    report_test("reset state", errs_before);

    // Broadcast then read back
    errs_before = errors;
    resp_log.delete();
    scalar = $random(seed);
    r      = $random(seed);
    vreg   = vreg_idx_t'(r[4:0]);
    send_insn(VMV_VX, vreg, '0, '0, scalar);
    send_insn(VMV_XS, '0, '0, vreg, '0);
    send_insn(VREDSUM, '0, '0, vreg, '0);
    wait_idle();
    wait_responses();
    check_count("response count", resp_log.size(), 2);
    if (resp_log.size() == 2) begin
      check_elem("resp_data_o", resp_log[0], scalar);
      check_elem("resp_data_o", resp_log[1], elem_t'(scalar * 16));
    end
    report_test("broadcast then read", errs_before);

    // Random mix on registers that all hold data
    errs_before = errors;
    for (int v = 0; v < nr_vregs; v++) begin
      scalar = $random(seed);
      send_insn(VMV_VX, vreg_idx_t'(v), '0, '0, scalar);
    end
    for (int n = 0; n < 200; n++) begin
      r      = $random(seed);
      scalar = $random(seed);
      send_insn(vec_op_e'(r[2:0]), vreg_idx_t'(r[7:3]), vreg_idx_t'(r[12:8]),
                vreg_idx_t'(r[17:13]), scalar);
    end
    wait_idle();
    wait_responses();
    report_test("random mix", errs_before);

    // Credits back to full depth
    errs_before = errors;
    check_count("insn credits", credits, queue_depth);
    report_test("credit return", errs_before);

    // Drain and response count
    errs_before = errors;
    check_count("idle_o", int'(idle_o), 1);
    check_count("response count", resp_count, resp_expected);
    check_count("pending expected responses", exp_q.size(), 0);
    report_test("drain", errs_before);

    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
